/* include/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DC_WAYS 4
`define DC_SETS 16
`define DC_WORDS 4

// bus widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

// address split, two low bits select the byte
`define DC_INDEX_W ($clog2(`DC_SETS))
`define DC_OFFSET_W ($clog2(`DC_WORDS))
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W - 2)

`endif

/* list.f */
+incdir+include
logic/dcache_pkg.sv
logic/mem_line_if.sv
logic/tag_store.sv
logic/data_store.sv
logic/plru_tree.sv
logic/axi_lite_master.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/axi_mem_model.sv
sim/tb_dcache.sv

/* logic/axi_lite_master.sv */
`default_nettype none

`include "dcache_macros.svh"

module axi_lite_master (
	input logic i_clk,
	input logic i_rst,

	mem_line_if.master mif,

	output logic [`DC_ADDR_W-1:0] o_m_awaddr,
	output logic o_m_awvalid,
	input logic i_m_awready,
	output logic [`DC_DATA_W-1:0] o_m_wdata,
	output logic [`DC_DATA_W/8-1:0] o_m_wstrb,
	output logic o_m_wvalid,
	input logic i_m_wready,
	input logic i_m_bvalid,
	output logic o_m_bready,
	output logic [`DC_ADDR_W-1:0] o_m_araddr,
	output logic o_m_arvalid,
	input logic i_m_arready,
	input logic [`DC_DATA_W-1:0] i_m_rdata,
	input logic i_m_rvalid,
	output logic o_m_rready
);

	localparam logic [1:0] M_IDLE = 2'd0;
	localparam logic [1:0] M_PREP = 2'd1;
	localparam logic [1:0] M_XFER = 2'd2;

	logic [1:0] state;
	logic write_q, done_q;
	logic [`DC_OFFSET_W-1:0] word_idx_q;
	dcache_pkg::cache_addr_u base_q, cur_addr;
	logic b_hs, r_hs;

	// word address inside the line
	always_comb begin
		cur_addr = base_q;
		cur_addr.f.offset = word_idx_q;
		cur_addr.f.byte_off = 2'b00;
	end

	assign o_m_awaddr = cur_addr.raw;
	assign o_m_araddr = cur_addr.raw;
	// registered store read, stable while wvalid waits
	assign o_m_wdata = mif.wdata;
	assign o_m_wstrb = '1;
	assign o_m_bready = state == M_XFER && write_q;
	assign o_m_rready = state == M_XFER && !write_q;

	assign b_hs = i_m_bvalid && o_m_bready;
	assign r_hs = i_m_rvalid && o_m_rready;

	assign mif.word_idx = word_idx_q;
	assign mif.rvalid = r_hs;
	assign mif.rdata = i_m_rdata;
	assign mif.done = done_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= M_IDLE;
			word_idx_q <= '0;
			o_m_awvalid <= 1'b0;
			o_m_wvalid <= 1'b0;
			o_m_arvalid <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				M_IDLE:
					if (mif.start) begin
						write_q <= mif.write;
						base_q.raw <= mif.line_addr;
						word_idx_q <= '0;
						state <= M_PREP;
					end
				// gives the data store a cycle to present the word
				M_PREP: begin
					o_m_awvalid <= write_q;
					o_m_wvalid <= write_q;
					o_m_arvalid <= !write_q;
					state <= M_XFER;
				end
				M_XFER: begin
					if (o_m_awvalid && i_m_awready)
						o_m_awvalid <= 1'b0;
					if (o_m_wvalid && i_m_wready)
						o_m_wvalid <= 1'b0;
					if (o_m_arvalid && i_m_arready)
						o_m_arvalid <= 1'b0;
					if (b_hs || r_hs) begin
						if (&word_idx_q) begin
							done_q <= 1'b1;
							state <= M_IDLE;
						end else begin
							word_idx_q <= word_idx_q + 1'b1;
							state <= M_PREP;
						end
					end
				end
				default:
					state <= M_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/data_store.sv */
`default_nettype none

`include "dcache_macros.svh"

module data_store (
	input logic i_clk,
	input logic [`DC_INDEX_W-1:0] i_rd_index,
	input logic [`DC_OFFSET_W-1:0] i_rd_offset,
	input logic i_we,
	input dcache_pkg::way_t i_way,
	input logic [`DC_INDEX_W-1:0] i_wr_index,
	input logic [`DC_OFFSET_W-1:0] i_wr_offset,
	input logic [`DC_DATA_W/8-1:0] i_wstrb,
	input logic [`DC_DATA_W-1:0] i_wdata,
	output logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] o_words
);

	logic [`DC_DATA_W-1:0] mem [`DC_WAYS][`DC_SETS][`DC_WORDS];

	always_ff @(posedge i_clk) begin
		// byte lanes under the strobe
		if (i_we) begin
			for (int b = 0; b < `DC_DATA_W/8; b++) begin
				if (i_wstrb[b])
					mem[i_way][i_wr_index][i_wr_offset][8*b +: 8] <= i_wdata[8*b +: 8];
			end
		end

		// same word from every way
		for (int w = 0; w < `DC_WAYS; w++)
			o_words[w] <= mem[w][i_rd_index][i_rd_offset];
	end

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl (
	input logic i_clk,
	input logic i_rst,

	input logic i_req_valid,
	input logic [`DC_ADDR_W-1:0] i_req_addr,
	input logic [`DC_DATA_W/8-1:0] i_req_wstrb,
	input logic [`DC_DATA_W-1:0] i_req_wdata,
	output logic o_req_ready,
	output logic o_rsp_valid,
	output logic [`DC_DATA_W-1:0] o_rsp_rdata,

	mem_line_if.ctrl mif,

	input dcache_pkg::tag_entry_t [`DC_WAYS-1:0] i_tags,
	input logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] i_words,
	input logic i_sweeping,
	input dcache_pkg::way_t i_victim,

	output logic [`DC_INDEX_W-1:0] o_rd_index,
	output logic [`DC_OFFSET_W-1:0] o_rd_offset,

	output logic o_tag_we,
	output dcache_pkg::way_t o_tag_way,
	output logic [`DC_INDEX_W-1:0] o_tag_index,
	output dcache_pkg::tag_entry_t o_tag_wdata,

	output logic o_data_we,
	output dcache_pkg::way_t o_data_way,
	output logic [`DC_INDEX_W-1:0] o_data_index,
	output logic [`DC_OFFSET_W-1:0] o_data_offset,
	output logic [`DC_DATA_W/8-1:0] o_data_wstrb,
	output logic [`DC_DATA_W-1:0] o_data_wdata,

	output logic o_plru_touch,
	output logic [`DC_INDEX_W-1:0] o_plru_index,
	output dcache_pkg::way_t o_plru_way
);

	dcache_pkg::ctrl_state_e state;
	dcache_pkg::cache_addr_u req_in, req_q;
	dcache_pkg::cache_addr_u victim_line, fill_line;
	dcache_pkg::tag_entry_t victim_tag;
	dcache_pkg::way_t victim_q, hit_way;
	logic [`DC_DATA_W/8-1:0] wstrb_q;
	logic [`DC_DATA_W-1:0] wdata_q, hit_word, merged;
	logic [`DC_WAYS-1:0] hit_vec;
	logic lookup_hit, lookup_miss, in_refill;
	logic start_q, write_q;
	logic [`DC_ADDR_W-1:0] line_addr_q;

	assign req_in.raw = i_req_addr;
	assign in_refill = state == dcache_pkg::REFILL;

	// tag compare and response mux
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			hit_vec[w] = i_tags[w].valid && i_tags[w].tag == req_q.f.tag;
			if (hit_vec[w])
				hit_way = dcache_pkg::way_t'(w);
		end
		hit_word = i_words[hit_way];
		for (int b = 0; b < `DC_DATA_W/8; b++)
			merged[8*b +: 8] = wstrb_q[b] ? wdata_q[8*b +: 8] : hit_word[8*b +: 8];
	end

	assign lookup_hit = state == dcache_pkg::LOOKUP && |hit_vec;
	assign lookup_miss = state == dcache_pkg::LOOKUP && !(|hit_vec);

	// line addresses of the victim and of the requested line
	assign victim_tag = i_tags[i_victim];
	assign victim_line.f = '{tag: victim_tag.tag, index: req_q.f.index, offset: '0,
		byte_off: '0};
	assign fill_line.f = '{tag: req_q.f.tag, index: req_q.f.index, offset: '0, byte_off: '0};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= dcache_pkg::SWEEP;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				dcache_pkg::SWEEP:
					if (!i_sweeping)
						state <= dcache_pkg::IDLE;
				dcache_pkg::IDLE:
					if (i_req_valid)
						state <= dcache_pkg::LOOKUP;
				dcache_pkg::LOOKUP:
					if (|hit_vec) begin
						state <= dcache_pkg::IDLE;
					end else begin
						start_q <= 1'b1;
						state <= victim_tag.valid ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
					end
				dcache_pkg::WRITEBACK:
					if (mif.done) begin
						start_q <= 1'b1;
						state <= dcache_pkg::REFILL;
					end
				dcache_pkg::REFILL:
					// replay, the new line now hits
					if (mif.done)
						state <= dcache_pkg::LOOKUP;
				default:
					state <= dcache_pkg::SWEEP;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req_valid && o_req_ready) begin
			req_q <= req_in;
			wstrb_q <= i_req_wstrb;
			wdata_q <= i_req_wdata;
		end
		if (lookup_miss) begin
			victim_q <= i_victim;
			write_q <= victim_tag.valid;
			line_addr_q <= victim_tag.valid ? victim_line.raw : fill_line.raw;
		end else if (state == dcache_pkg::WRITEBACK && mif.done) begin
			write_q <= 1'b0;
			line_addr_q <= fill_line.raw;
		end
	end

	assign o_req_ready = state == dcache_pkg::IDLE;
	assign o_rsp_valid = lookup_hit;
	assign o_rsp_rdata = merged;

	assign mif.start = start_q;
	assign mif.write = write_q;
	assign mif.line_addr = line_addr_q;
	assign mif.wdata = i_words[victim_q];

	// read the incoming request in idle, the write-back word while draining
	assign o_rd_index = o_req_ready ? req_in.f.index : req_q.f.index;
	assign o_rd_offset = o_req_ready ? req_in.f.offset :
		state == dcache_pkg::WRITEBACK ? mif.word_idx : req_q.f.offset;

	assign o_tag_we = in_refill && mif.done;
	assign o_tag_way = victim_q;
	assign o_tag_index = req_q.f.index;
	assign o_tag_wdata = '{valid: 1'b1, tag: req_q.f.tag};

	// refill words or the merged store word
	assign o_data_we = (in_refill && mif.rvalid) || (lookup_hit && |wstrb_q);
	assign o_data_way = in_refill ? victim_q : hit_way;
	assign o_data_index = req_q.f.index;
	assign o_data_offset = in_refill ? mif.word_idx : req_q.f.offset;
	assign o_data_wstrb = in_refill ? '1 : wstrb_q;
	assign o_data_wdata = in_refill ? mif.rdata : merged;

	assign o_plru_touch = lookup_hit || o_tag_we;
	assign o_plru_index = req_q.f.index;
	assign o_plru_way = in_refill ? victim_q : hit_way;

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	// field view of a byte address
	typedef struct packed {
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_INDEX_W-1:0] index;
		logic [`DC_OFFSET_W-1:0] offset;
		logic [1:0] byte_off;
	} addr_fields_t;

	// raw word on the bus, fields for the lookup
	typedef union packed {
		logic [`DC_ADDR_W-1:0] raw;
		addr_fields_t f;
	} cache_addr_u;

	typedef struct packed {
		logic valid;
		logic [`DC_TAG_W-1:0] tag;
	} tag_entry_t;

	typedef logic [1:0] way_t;

	// bit 0 root, bit 1 ways 0-1, bit 2 ways 2-3
	typedef logic [2:0] plru_t;

	typedef enum logic [2:0] {
		SWEEP,
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL
	} ctrl_state_e;

endpackage

`default_nettype wire

/* logic/dcache_top.sv */
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
	input logic i_clk,
	input logic i_rst,

	// core port
	input logic i_req_valid,
	input logic [`DC_ADDR_W-1:0] i_req_addr,
	input logic [`DC_DATA_W/8-1:0] i_req_wstrb,
	input logic [`DC_DATA_W-1:0] i_req_wdata,
	output logic o_req_ready,
	output logic o_rsp_valid,
	output logic [`DC_DATA_W-1:0] o_rsp_rdata,

	// axi4-lite master
	output logic [`DC_ADDR_W-1:0] o_m_awaddr,
	output logic o_m_awvalid,
	input logic i_m_awready,
	output logic [`DC_DATA_W-1:0] o_m_wdata,
	output logic [`DC_DATA_W/8-1:0] o_m_wstrb,
	output logic o_m_wvalid,
	input logic i_m_wready,
	input logic i_m_bvalid,
	output logic o_m_bready,
	output logic [`DC_ADDR_W-1:0] o_m_araddr,
	output logic o_m_arvalid,
	input logic i_m_arready,
	input logic [`DC_DATA_W-1:0] i_m_rdata,
	input logic i_m_rvalid,
	output logic o_m_rready
);

	dcache_pkg::tag_entry_t [`DC_WAYS-1:0] tags;
	logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] words;
	logic sweeping;
	dcache_pkg::way_t victim;

	logic [`DC_INDEX_W-1:0] rd_index;
	logic [`DC_OFFSET_W-1:0] rd_offset;

	logic tag_we;
	dcache_pkg::way_t tag_way;
	logic [`DC_INDEX_W-1:0] tag_index;
	dcache_pkg::tag_entry_t tag_wdata;

	logic data_we;
	dcache_pkg::way_t data_way;
	logic [`DC_INDEX_W-1:0] data_index;
	logic [`DC_OFFSET_W-1:0] data_offset;
	logic [`DC_DATA_W/8-1:0] data_wstrb;
	logic [`DC_DATA_W-1:0] data_wdata;

	logic plru_touch;
	logic [`DC_INDEX_W-1:0] plru_index;
	dcache_pkg::way_t plru_way;

	mem_line_if mif_i ();

	dcache_ctrl ctrl_i (
		.i_clk, .i_rst,
		.i_req_valid, .i_req_addr, .i_req_wstrb, .i_req_wdata,
		.o_req_ready, .o_rsp_valid, .o_rsp_rdata,
		.mif(mif_i),
		.i_tags(tags), .i_words(words), .i_sweeping(sweeping), .i_victim(victim),
		.o_rd_index(rd_index), .o_rd_offset(rd_offset),
		.o_tag_we(tag_we), .o_tag_way(tag_way), .o_tag_index(tag_index),
		.o_tag_wdata(tag_wdata),
		.o_data_we(data_we), .o_data_way(data_way), .o_data_index(data_index),
		.o_data_offset(data_offset), .o_data_wstrb(data_wstrb), .o_data_wdata(data_wdata),
		.o_plru_touch(plru_touch), .o_plru_index(plru_index), .o_plru_way(plru_way)
	);

	tag_store tag_store_i (
		.i_clk, .i_rst,
		.i_rd_index(rd_index), .i_we(tag_we), .i_way(tag_way),
		.i_wr_index(tag_index), .i_wdata(tag_wdata),
		.o_tags(tags), .o_sweeping(sweeping)
	);

	data_store data_store_i (
		.i_clk,
		.i_rd_index(rd_index), .i_rd_offset(rd_offset),
		.i_we(data_we), .i_way(data_way), .i_wr_index(data_index),
		.i_wr_offset(data_offset), .i_wstrb(data_wstrb), .i_wdata(data_wdata),
		.o_words(words)
	);

	plru_tree plru_i (
		.i_clk, .i_rst,
		.i_index(plru_index), .i_touch(plru_touch), .i_way(plru_way),
		.o_victim(victim)
	);

	axi_lite_master axi_i (
		.i_clk, .i_rst,
		.mif(mif_i),
		.o_m_awaddr, .o_m_awvalid, .i_m_awready,
		.o_m_wdata, .o_m_wstrb, .o_m_wvalid, .i_m_wready,
		.i_m_bvalid, .o_m_bready,
		.o_m_araddr, .o_m_arvalid, .i_m_arready,
		.i_m_rdata, .i_m_rvalid, .o_m_rready
	);

endmodule

`default_nettype wire

/* logic/mem_line_if.sv */
`default_nettype none

`include "dcache_macros.svh"

// line transfer between controller and bus master
interface mem_line_if;
	logic start;
	logic write;
	logic [`DC_ADDR_W-1:0] line_addr;
	logic [`DC_DATA_W-1:0] wdata;
	logic [`DC_OFFSET_W-1:0] word_idx;
	logic rvalid;
	logic [`DC_DATA_W-1:0] rdata;
	logic done;

	modport ctrl (output start, write, line_addr, wdata,
		input word_idx, rvalid, rdata, done);
	modport master (input start, write, line_addr, wdata,
		output word_idx, rvalid, rdata, done);
endinterface

`default_nettype wire

/* logic/plru_tree.sv */
`default_nettype none

`include "dcache_macros.svh"

module plru_tree (
	input logic i_clk,
	input logic i_rst,
	input logic [`DC_INDEX_W-1:0] i_index,
	input logic i_touch,
	input dcache_pkg::way_t i_way,
	output dcache_pkg::way_t o_victim
);

	dcache_pkg::plru_t bits_q [`DC_SETS];
	dcache_pkg::plru_t cur;

	assign cur = bits_q[i_index];

	// follow root, then the pair bit
	assign o_victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < `DC_SETS; s++)
				bits_q[s] <= '0;
		end else if (i_touch) begin
			// point away from the accessed way
			if (!i_way[1]) begin
				bits_q[i_index][0] <= 1'b1;
				bits_q[i_index][1] <= ~i_way[0];
			end else begin
				bits_q[i_index][0] <= 1'b0;
				bits_q[i_index][2] <= ~i_way[0];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/tag_store.sv */
`default_nettype none

`include "dcache_macros.svh"

module tag_store (
	input logic i_clk,
	input logic i_rst,
	input logic [`DC_INDEX_W-1:0] i_rd_index,
	input logic i_we,
	input dcache_pkg::way_t i_way,
	input logic [`DC_INDEX_W-1:0] i_wr_index,
	input dcache_pkg::tag_entry_t i_wdata,
	output dcache_pkg::tag_entry_t [`DC_WAYS-1:0] o_tags,
	output logic o_sweeping
);

	dcache_pkg::tag_entry_t mem [`DC_WAYS][`DC_SETS];
	logic [`DC_INDEX_W-1:0] sweep_cnt;

	// one set per cycle after reset
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sweep_cnt <= '0;
			o_sweeping <= 1'b1;
		end else if (o_sweeping) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (&sweep_cnt)
				o_sweeping <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_sweeping) begin
			for (int w = 0; w < `DC_WAYS; w++)
				mem[w][sweep_cnt] <= '0;
		end else if (i_we) begin
			mem[i_way][i_wr_index] <= i_wdata;
		end

		// write-first so the replay after a refill sees the new tag
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (!o_sweeping && i_we && i_way == dcache_pkg::way_t'(w) &&
				i_wr_index == i_rd_index)
				o_tags[w] <= i_wdata;
			else
				o_tags[w] <= mem[w][i_rd_index];
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f list.f

out=$(./obj_dir/Vtb_dcache)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Finished with no errors'; then
	exit 0
fi
exit 1

/* sim/axi_mem_model.sv */
`default_nettype none

`include "dcache_macros.svh"

// axi4-lite slave memory with one transaction per channel at a time
module axi_mem_model #(
	parameter int unsigned SEED = 1,
	parameter int WORDS = 4096
) (
	input logic i_clk,
	input logic i_rst,
	input logic [`DC_ADDR_W-1:0] i_awaddr,
	input logic i_awvalid,
	output logic o_awready,
	input logic [`DC_DATA_W-1:0] i_wdata,
	input logic [`DC_DATA_W/8-1:0] i_wstrb,
	input logic i_wvalid,
	output logic o_wready,
	output logic o_bvalid,
	input logic i_bready,
	input logic [`DC_ADDR_W-1:0] i_araddr,
	input logic i_arvalid,
	output logic o_arready,
	output logic [`DC_DATA_W-1:0] o_rdata,
	output logic o_rvalid,
	input logic i_rready,
	output int o_aw_count,
	output int o_ar_count
);

	localparam int IDX_W = $clog2(WORDS);

	logic [`DC_DATA_W-1:0] mem [WORDS];
	logic tick;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// fill value mixes the full byte address into the seed
	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = xorshift32(xorshift32(SEED ^ (32'(i) << 2)));
		tick = 1'b0;
		o_bvalid = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_aw_count = 0;
		o_ar_count = 0;
	end

	// ready only on every other cycle for some back-pressure on each channel
	assign o_awready = i_awvalid && i_wvalid && !o_bvalid && tick;
	assign o_wready = o_awready;
	assign o_arready = i_arvalid && !o_rvalid && tick;

	always @(posedge i_clk) begin
		if (i_rst) begin
			tick <= 1'b0;
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
			o_aw_count <= 0;
			o_ar_count <= 0;
		end else begin
			tick <= ~tick;
			if (o_awready) begin
				for (int b = 0; b < `DC_DATA_W/8; b++) begin
					if (i_wstrb[b])
						mem[i_awaddr[IDX_W+1:2]][8*b +: 8] <= i_wdata[8*b +: 8];
				end
				o_bvalid <= 1'b1;
				o_aw_count <= o_aw_count + 1;
			end else if (o_bvalid && i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (o_arready) begin
				o_rdata <= mem[i_araddr[IDX_W+1:2]];
				o_rvalid <= 1'b1;
				o_ar_count <= o_ar_count + 1;
			end else if (o_rvalid && i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_dcache.sv */
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;

	localparam int SEED = 10154;
	localparam int MEM_WORDS = 4096;
	localparam int IDX_W = $clog2(MEM_WORDS);
	// worst case per miss is a full write-back plus refill under back-pressure
	localparam int MAX_REQS = 60;
	localparam int MISS_CYCLES = 48;
	localparam int TIMEOUT_CYCLES = MAX_REQS * MISS_CYCLES + `DC_SETS + 104;

	logic clk, rst;
	logic req_valid, req_ready, rsp_valid;
	logic [`DC_ADDR_W-1:0] req_addr;
	logic [`DC_DATA_W/8-1:0] req_wstrb;
	logic [`DC_DATA_W-1:0] req_wdata, rsp_rdata;

	logic [`DC_ADDR_W-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`DC_DATA_W-1:0] wdata, rdata;
	logic [`DC_DATA_W/8-1:0] wstrb;
	int aw_count, ar_count;

	// latest value of every word with the tags and plru bits of the model
	logic [31:0] ref_data [MEM_WORDS];
	logic ref_valid [`DC_SETS][`DC_WAYS];
	logic [`DC_TAG_W-1:0] ref_tag [`DC_SETS][`DC_WAYS];
	logic [2:0] ref_plru [`DC_SETS];

	int errors, checks, cycles;

	dcache_top dut_i (
		.i_clk(clk), .i_rst(rst),
		.i_req_valid(req_valid), .i_req_addr(req_addr), .i_req_wstrb(req_wstrb),
		.i_req_wdata(req_wdata), .o_req_ready(req_ready), .o_rsp_valid(rsp_valid),
		.o_rsp_rdata(rsp_rdata),
		.o_m_awaddr(awaddr), .o_m_awvalid(awvalid), .i_m_awready(awready),
		.o_m_wdata(wdata), .o_m_wstrb(wstrb), .o_m_wvalid(wvalid), .i_m_wready(wready),
		.i_m_bvalid(bvalid), .o_m_bready(bready),
		.o_m_araddr(araddr), .o_m_arvalid(arvalid), .i_m_arready(arready),
		.i_m_rdata(rdata), .i_m_rvalid(rvalid), .o_m_rready(rready)
	);

	axi_mem_model #(.SEED(SEED), .WORDS(MEM_WORDS)) mem_i (
		.i_clk(clk), .i_rst(rst),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
		.o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rvalid(rvalid), .i_rready(rready),
		.o_aw_count(aw_count), .o_ar_count(ar_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

	function automatic logic [31:0] make_addr(input logic [31:0] tag, input logic [31:0] set,
		input logic [31:0] word);
		return (tag << (`DC_INDEX_W + `DC_OFFSET_W + 2)) | (set << (`DC_OFFSET_W + 2)) |
			(word << 2);
	endfunction

	function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
		return addr[IDX_W+1:2];
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] upd,
		input logic [3:0] strb);
		logic [31:0] r;
		for (int b = 0; b < 4; b++)
			r[8*b +: 8] = strb[b] ? upd[8*b +: 8] : old[8*b +: 8];
		return r;
	endfunction

	// lower pair when the root is zero, then the pair bit picks the way
	function automatic logic [1:0] victim_way(input logic [2:0] bits);
		if (!bits[0])
			return bits[1] ? 2'd1 : 2'd0;
		else
			return bits[2] ? 2'd3 : 2'd2;
	endfunction

	// root and pair bit both point away from the accessed way
	function automatic logic [2:0] touched_bits(input logic [2:0] bits, input logic [1:0] way);
		logic [2:0] b;
		b = bits;
		case (way)
			2'd0: begin
				b[0] = 1'b1;
				b[1] = 1'b1;
			end
			2'd1: begin
				b[0] = 1'b1;
				b[1] = 1'b0;
			end
			2'd2: begin
				b[0] = 1'b0;
				b[2] = 1'b1;
			end
			default: begin
				b[0] = 1'b0;
				b[2] = 1'b0;
			end
		endcase
		return b;
	endfunction

	function automatic logic [`DC_TAG_W-1:0] victim_tag(input logic [`DC_INDEX_W-1:0] set);
		return ref_tag[set][victim_way(ref_plru[set])];
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("at time %0t: %s", $time, what);
		end
	endtask

	// one request through the core port checked against the reference model
	task automatic access(input logic [31:0] addr, input logic [3:0] strb,
		input logic [31:0] data);
		logic [`DC_INDEX_W-1:0] set;
		logic [`DC_TAG_W-1:0] tag;
		logic [1:0] way;
		logic hit, evict;
		logic [31:0] exp_word, evict_base;
		int lat, ar0, aw0;
		set = addr[`DC_OFFSET_W+2 +: `DC_INDEX_W];
		tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
		hit = 1'b0;
		evict = 1'b0;
		way = 2'd0;
		evict_base = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
				hit = 1'b1;
				way = 2'(w);
			end
		end
		if (!hit) begin
			way = victim_way(ref_plru[set]);
			evict = ref_valid[set][way];
			evict_base = make_addr(32'(ref_tag[set][way]), 32'(set), 0);
			ref_valid[set][way] = 1'b1;
			ref_tag[set][way] = tag;
		end
		// refill and replay both touch the same way
		ref_plru[set] = touched_bits(ref_plru[set], way);
		exp_word = merge_bytes(ref_data[word_index(addr)], data, strb);
		ref_data[word_index(addr)] = exp_word;

		ar0 = ar_count;
		aw0 = aw_count;
		while (!req_ready)
			@(negedge clk);
		req_valid = 1'b1;
		req_addr = addr;
		req_wstrb = strb;
		req_wdata = data;
		@(negedge clk);
		req_valid = 1'b0;
		lat = 1;
		while (!rsp_valid) begin
			@(negedge clk);
			lat++;
		end

		compare_word("o_rsp_rdata", rsp_rdata, exp_word);
		if (hit)
			require(lat == 1, "hit response did not come one cycle after acceptance");
		compare_word("AR handshakes", 32'(ar_count - ar0), hit ? 0 : `DC_WORDS);
		compare_word("AW handshakes", 32'(aw_count - aw0), evict ? `DC_WORDS : 0);
		if (evict) begin
			for (int w = 0; w < `DC_WORDS; w++)
				compare_word("written-back word", mem_i.mem[word_index(evict_base) + IDX_W'(w)],
					ref_data[word_index(evict_base) + IDX_W'(w)]);
		end
		@(negedge clk);
		require(!rsp_valid && req_ready,
			"response was not a single pulse followed by ready in the next cycle");
	endtask

	task automatic apply_reset();
		repeat (2) @(negedge clk);
		require(!req_ready && !rsp_valid, "core handshake output high after reset");
		require(!awvalid && !wvalid && !arvalid && !bready && !rready,
			"AXI handshake output high after reset");
		rst = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_data[i] = mem_i.mem[i];
		for (int s = 0; s < `DC_SETS; s++) begin
			ref_plru[s] = 3'b000;
			for (int w = 0; w < `DC_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w] = '0;
			end
		end
	endtask

	task automatic reset_and_cold_miss();
		int wait_cycles;
		wait_cycles = 0;
		while (!req_ready) begin
			@(negedge clk);
			wait_cycles++;
		end
		require(wait_cycles >= `DC_SETS, "ready rose before the tag sweep could finish");
		access(make_addr(1, 3, 2), 4'b0000, 32'h0);
	endtask

	task automatic repeat_read_hits();
		access(make_addr(1, 3, 2), 4'b0000, 32'h0);
		access(make_addr(1, 3, 0), 4'b0000, 32'h0);
		access(make_addr(1, 3, 2), 4'b0000, 32'h0);
	endtask

	task automatic byte_write_hit();
		access(make_addr(1, 3, 2), 4'b0101, 32'hA5C3_1E77);
		access(make_addr(1, 3, 2), 4'b0000, 32'h0);
		access(make_addr(1, 3, 2), 4'b1000, 32'h7E00_0000);
		access(make_addr(1, 3, 2), 4'b0000, 32'h0);
	endtask

	// merge happens into the refilled line
	task automatic write_miss_refill();
		access(make_addr(2, 5, 1), 4'b1100, 32'h1234_5678);
		access(make_addr(2, 5, 1), 4'b0000, 32'h0);
		access(make_addr(2, 5, 3), 4'b0000, 32'h0);
	endtask

	task automatic evict_and_write_back();
		logic [`DC_TAG_W-1:0] old_tag;
		int aw0;
		for (int t = 10; t < 14; t++)
			access(make_addr(t, 7, t % 4), 4'b1111, 32'hC0DE_0000 | t);
		old_tag = victim_tag(4'd7);
		aw0 = aw_count;
		access(make_addr(14, 7, 0), 4'b0000, 32'h0);
		compare_word("AW handshakes on eviction", 32'(aw_count - aw0), `DC_WORDS);
		// store data of the evicted line comes back from memory
		access(make_addr(32'(old_tag), 7, 32'(old_tag) & 32'd3), 4'b0000, 32'h0);
	endtask

	task automatic replacement_order();
		logic [`DC_TAG_W-1:0] old_tag;
		int ar0;
		for (int t = 20; t < 24; t++)
			access(make_addr(t, 9, 0), 4'b0000, 32'h0);
		// tree ends up pointing at tag 22 although tag 21 is older
		access(make_addr(22, 9, 1), 4'b0000, 32'h0);
		access(make_addr(20, 9, 2), 4'b0000, 32'h0);
		access(make_addr(23, 9, 3), 4'b0000, 32'h0);
		old_tag = victim_tag(4'd9);
		access(make_addr(24, 9, 0), 4'b0000, 32'h0);
		for (int t = 20; t < 24; t++) begin
			if (t != int'(old_tag))
				access(make_addr(t, 9, 1), 4'b0000, 32'h0);
		end
		ar0 = ar_count;
		access(make_addr(32'(old_tag), 9, 0), 4'b0000, 32'h0);
		compare_word("AR handshakes on victim re-read", 32'(ar_count - ar0), `DC_WORDS);
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		req_wstrb = '0;
		req_wdata = '0;
		errors = 0;
		checks = 0;
		apply_reset();
		reset_and_cold_miss();
		repeat_read_hits();
		byte_write_hit();
		write_miss_refill();
		evict_and_write_back();
		replacement_order();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
